// ==== source/bitSyncPkg.sv ====
package bitSyncPkg;

    // Datapath widths
    localparam int sampleWidthDefault = 18;
    localparam int freqWidth = 32;
    localparam int errorWidth = 8;
    localparam int lockCountWidth = 16;

    // Error values with a transition per lock averaging window
    localparam int avgTransitions = 16;

    // Register port
    localparam int regAddrWidth = 4;
    localparam int regDataWidth = 32;
    localparam int shiftWidth = 5;

    localparam logic [regAddrWidth-1:0] regNomFreq = 4'd0;
    localparam logic [regAddrWidth-1:0] regGains = 4'd1;
    localparam logic [regAddrWidth-1:0] regControl = 4'd2;
    localparam logic [regAddrWidth-1:0] regLockCount = 4'd3;
    localparam logic [regAddrWidth-1:0] regSampleFreq = 4'd4;

    // Rail mode field of regControl
    localparam logic railSingle = 1'b0;
    localparam logic railDual = 1'b1;

    // Largest shift turns the gain off
    localparam logic [shiftWidth-1:0] zeroGainShift = 5'd31;

    // Four samples per strobe
    localparam logic [freqWidth-1:0] nomFreqReset = 32'h4000_0000;
    localparam logic [lockCountWidth-1:0] lockCountReset = 16'd4;

endpackage

// ==== source/sampleSummer.sv ====
`timescale 1ns/1ns

module sampleSummer #(
    parameter int sampleWidth = bitSyncPkg::sampleWidthDefault
) (
    input  logic                          sampleClk,
    input  logic                          reset,
    input  logic                          strobe,
    input  logic                          useSummer,
    input  logic signed [sampleWidth-1:0] i,
    input  logic signed [sampleWidth-1:0] q,
    output logic signed [sampleWidth-1:0] mfI,
    output logic signed [sampleWidth-1:0] mfQ
);

    logic signed [sampleWidth-1:0] iDelay;
    logic signed [sampleWidth-1:0] qDelay;
    logic signed [sampleWidth:0]   iSum;
    logic signed [sampleWidth:0]   qSum;

    // Extend first so the sum cannot wrap
    assign iSum = {iDelay[sampleWidth-1], iDelay} + {i[sampleWidth-1], i};
    assign qSum = {qDelay[sampleWidth-1], qDelay} + {q[sampleWidth-1], q};

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            iDelay <= '0;
            qDelay <= '0;
            mfI <= '0;
            mfQ <= '0;
        end else if (strobe) begin
            iDelay <= i;
            qDelay <= q;
            if (useSummer) begin
                mfI <= iSum[sampleWidth:1];
                mfQ <= qSum[sampleWidth:1];
            end else begin
                mfI <= iDelay;
                mfQ <= qDelay;
            end
        end
    end

endmodule

// ==== source/timingErrorDetector.sv ====
`timescale 1ns/1ns

module timingErrorDetector #(
    parameter int sampleWidth = bitSyncPkg::sampleWidthDefault
) (
    input  logic                                     sampleClk,
    input  logic                                     reset,
    input  logic                                     strobe,
    input  logic                                     railMode,
    input  logic signed [sampleWidth-1:0]            mfI,
    input  logic signed [sampleWidth-1:0]            mfQ,
    output logic                                     symValid,
    output logic signed [sampleWidth-1:0]            symDataI,
    output logic signed [sampleWidth-1:0]            symDataQ,
    output logic                                     bitDataI,
    output logic                                     bitDataQ,
    output logic signed [bitSyncPkg::errorWidth-1:0] timingError,
    output logic                                     errorValid,
    output logic                                     transition,
    output logic [bitSyncPkg::errorWidth-1:0]        absError,
    output logic [bitSyncPkg::errorWidth-1:0]        absSlipError,
    output logic signed [sampleWidth-1:0]            offsetError,
    output logic                                     offsetErrorValid
);

    localparam int msb = sampleWidth - 1;

    // Index 0 late, 1 off-time, 2 early
    logic signed [msb:0]       srI [3];
    logic signed [msb:0]       srQ [3];
    logic                      offTime;
    logic                      onTimePulse;
    logic signed [msb:0]       errI;
    logic signed [msb:0]       errQ;
    logic signed [msb:0]       slipError;
    logic signed [sampleWidth:0] errSum;
    logic signed [sampleWidth:0] offsetSum;
    logic [msb:0]              errMag;
    logic [msb:0]              slipMag;
    logic                      transI;
    logic                      transQ;

    assign transI = srI[2][msb] != srI[0][msb];
    assign transQ = srQ[2][msb] != srQ[0][msb];
    assign offsetSum = {srI[2][msb], srI[2]} + {srI[0][msb], srI[0]};

    // Loop filter takes the top bits of the I+Q error
    assign errSum = {errI[msb], errI} + {errQ[msb], errQ};
    assign timingError = errSum[sampleWidth -: bitSyncPkg::errorWidth];

    assign errMag = errI[msb] ? -errI : errI;
    assign slipMag = slipError[msb] ? -slipError : slipError;
    assign absError = errMag[msb -: bitSyncPkg::errorWidth];
    assign absSlipError = slipMag[msb -: bitSyncPkg::errorWidth];

    assign symValid = onTimePulse;
    assign errorValid = onTimePulse;
    assign offsetErrorValid = onTimePulse;

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            offTime <= 1'b0;
            onTimePulse <= 1'b0;
            transition <= 1'b0;
            for (int k = 0; k < 3; k++) begin
                srI[k] <= '0;
                srQ[k] <= '0;
            end
        end else begin
            onTimePulse <= strobe && offTime;
            if (strobe) begin
                offTime <= !offTime;
                srI[0] <= mfI;
                srQ[0] <= (railMode == bitSyncPkg::railDual) ? mfQ : mfI;
                srI[1] <= srI[0];
                srI[2] <= srI[1];
                srQ[1] <= srQ[0];
                srQ[2] <= srQ[1];
                if (offTime) begin
                    transition <= transI;
                end
            end
        end
    end

    // Evaluated on the strobe that moves to on-time
    always_ff @(posedge sampleClk) begin
        if (strobe && offTime) begin
            // Late on-time sample carries the finished symbol
            symDataI <= srI[0];
            symDataQ <= srQ[0];
            bitDataI <= !srI[0][msb];
            bitDataQ <= !srQ[0][msb];
            if (transI) begin
                offsetError <= offsetSum[sampleWidth:1];
                // Early negative means the samples rise through zero
                if (srI[2][msb]) begin
                    errI <= srI[1];
                    slipError <= srI[0];
                end else begin
                    errI <= -srI[1];
                    slipError <= srI[2];
                end
            end else begin
                offsetError <= '0;
                errI <= '0;
            end
            if (transQ) begin
                errQ <= srQ[2][msb] ? srQ[1] : -srQ[1];
            end else begin
                errQ <= '0;
            end
        end
    end

endmodule

// ==== source/loopFilter.sv ====
`timescale 1ns/1ns

module loopFilter (
    input  logic                                     sampleClk,
    input  logic                                     reset,
    input  logic                                     sampleValid,
    input  logic                                     regWrite,
    input  logic [bitSyncPkg::regAddrWidth-1:0]      regAddr,
    input  logic [bitSyncPkg::regDataWidth-1:0]      regWriteData,
    input  logic signed [bitSyncPkg::errorWidth-1:0] timingError,
    input  logic                                     errorValid,
    output logic [bitSyncPkg::regDataWidth-1:0]      regReadData,
    output logic                                     halfSymStrobe,
    output logic [bitSyncPkg::freqWidth-1:0]         sampleFreq,
    output logic                                     useSummer,
    output logic                                     railMode,
    output logic [bitSyncPkg::lockCountWidth-1:0]    lockReload
);

    localparam int accWidth = bitSyncPkg::freqWidth;
    localparam int shiftWidth = bitSyncPkg::shiftWidth;

    logic [accWidth-1:0]        nomFreq;
    logic [shiftWidth-1:0]      propShift;
    logic [shiftWidth-1:0]      intShift;
    logic [accWidth-1:0]        phaseAcc;
    logic [accWidth:0]          phaseNext;
    logic signed [accWidth-1:0] scaledError;
    logic signed [accWidth-1:0] propTerm;
    logic signed [accWidth-1:0] intTerm;
    logic signed [accWidth-1:0] integrator;
    logic signed [accWidth-1:0] propReg;
    logic signed [accWidth+1:0] freqSum;

    // Error lines up with the top of the frequency word
    assign scaledError = {timingError, {(accWidth - bitSyncPkg::errorWidth){1'b0}}};

    always_comb begin
        propTerm = scaledError >>> propShift;
        intTerm = scaledError >>> intShift;
        if (propShift == bitSyncPkg::zeroGainShift) begin
            propTerm = '0;
        end
        if (intShift == bitSyncPkg::zeroGainShift) begin
            intTerm = '0;
        end
    end

    assign freqSum = $signed({2'b00, nomFreq}) + integrator + propReg;

    // Saturate at the unsigned limits
    always_comb begin
        if (freqSum[accWidth+1]) begin
            sampleFreq = '0;
        end else if (freqSum[accWidth]) begin
            sampleFreq = '1;
        end else begin
            sampleFreq = freqSum[accWidth-1:0];
        end
    end

    assign phaseNext = {1'b0, phaseAcc} + {1'b0, sampleFreq};

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            nomFreq <= bitSyncPkg::nomFreqReset;
            propShift <= bitSyncPkg::zeroGainShift;
            intShift <= bitSyncPkg::zeroGainShift;
            useSummer <= 1'b1;
            railMode <= bitSyncPkg::railSingle;
            lockReload <= bitSyncPkg::lockCountReset;
            integrator <= '0;
            propReg <= '0;
            phaseAcc <= '0;
            halfSymStrobe <= 1'b0;
        end else begin
            if (regWrite) begin
                case (regAddr)
                    bitSyncPkg::regNomFreq: nomFreq <= regWriteData[accWidth-1:0];
                    bitSyncPkg::regGains: begin
                        propShift <= regWriteData[shiftWidth-1:0];
                        intShift <= regWriteData[8 +: shiftWidth];
                    end
                    bitSyncPkg::regControl: begin
                        useSummer <= regWriteData[0];
                        railMode <= regWriteData[1];
                    end
                    bitSyncPkg::regLockCount: begin
                        lockReload <= regWriteData[bitSyncPkg::lockCountWidth-1:0];
                    end
                    default: ;
                endcase
            end
            if (errorValid) begin
                integrator <= integrator + intTerm;
                propReg <= propTerm;
            end
            // NCO carry marks each half symbol
            halfSymStrobe <= sampleValid && phaseNext[accWidth];
            if (sampleValid) begin
                phaseAcc <= phaseNext[accWidth-1:0];
            end
        end
    end

    always_comb begin
        regReadData = '0;
        case (regAddr)
            bitSyncPkg::regNomFreq: regReadData[accWidth-1:0] = nomFreq;
            bitSyncPkg::regGains: begin
                regReadData[shiftWidth-1:0] = propShift;
                regReadData[8 +: shiftWidth] = intShift;
            end
            bitSyncPkg::regControl: regReadData[1:0] = {railMode, useSummer};
            bitSyncPkg::regLockCount: begin
                regReadData[bitSyncPkg::lockCountWidth-1:0] = lockReload;
            end
            bitSyncPkg::regSampleFreq: regReadData[accWidth-1:0] = sampleFreq;
            default: ;
        endcase
    end

endmodule

// ==== source/lockDetector.sv ====
`timescale 1ns/1ns

module lockDetector (
    input  logic                                  sampleClk,
    input  logic                                  reset,
    input  logic                                  errorValid,
    input  logic                                  transition,
    input  logic [bitSyncPkg::errorWidth-1:0]     absError,
    input  logic [bitSyncPkg::errorWidth-1:0]     absSlipError,
    input  logic [bitSyncPkg::lockCountWidth-1:0] lockReload,
    output logic                                  bitSyncLock,
    output logic [bitSyncPkg::lockCountWidth-1:0] lockCounter
);

    localparam int countWidth = $clog2(bitSyncPkg::avgTransitions);
    localparam int accWidth = bitSyncPkg::errorWidth + countWidth;
    localparam logic [countWidth-1:0] lastIndex = countWidth'(bitSyncPkg::avgTransitions - 1);

    logic [countWidth-1:0] windowCount;
    logic [accWidth-1:0]   errorAcc;
    logic [accWidth-1:0]   slipAcc;
    logic                  windowEnd;
    logic                  windowFail;

    // Locked error sits well under the slip error
    assign windowFail = errorAcc > (slipAcc >> 1);

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            windowCount <= '0;
            errorAcc <= '0;
            slipAcc <= '0;
            windowEnd <= 1'b0;
            bitSyncLock <= 1'b0;
            lockCounter <= '0;
        end else begin
            windowEnd <= 1'b0;
            if (windowEnd) begin
                errorAcc <= '0;
                slipAcc <= '0;
                // Counter climbs to lockReload to lock, falls to zero to unlock
                if (windowFail) begin
                    if (lockCounter == '0) begin
                        bitSyncLock <= 1'b0;
                    end else begin
                        lockCounter <= lockCounter - 1'b1;
                    end
                end else if (lockCounter >= lockReload) begin
                    bitSyncLock <= 1'b1;
                    lockCounter <= lockReload;
                end else begin
                    lockCounter <= lockCounter + 1'b1;
                end
            end else if (errorValid && transition) begin
                errorAcc <= errorAcc + {{countWidth{1'b0}}, absError};
                slipAcc <= slipAcc + {{countWidth{1'b0}}, absSlipError};
                windowCount <= windowCount + 1'b1;
                if (windowCount == lastIndex) begin
                    windowEnd <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/bitSyncTop.sv ====
`timescale 1ns/1ns

module bitSyncTop #(
    parameter int sampleWidth = bitSyncPkg::sampleWidthDefault
) (
    input  logic                                  sampleClk,
    input  logic                                  reset,
    input  logic signed [sampleWidth-1:0]         i,
    input  logic signed [sampleWidth-1:0]         q,
    input  logic                                  sampleValid,
    input  logic                                  regWrite,
    input  logic [bitSyncPkg::regAddrWidth-1:0]   regAddr,
    input  logic [bitSyncPkg::regDataWidth-1:0]   regWriteData,
    output logic [bitSyncPkg::regDataWidth-1:0]   regReadData,
    output logic                                  symValid,
    output logic signed [sampleWidth-1:0]         symDataI,
    output logic signed [sampleWidth-1:0]         symDataQ,
    output logic                                  bitDataI,
    output logic                                  bitDataQ,
    output logic signed [sampleWidth-1:0]         offsetError,
    output logic                                  offsetErrorValid,
    output logic [bitSyncPkg::freqWidth-1:0]      sampleFreq,
    output logic                                  bitSyncLock,
    output logic [bitSyncPkg::lockCountWidth-1:0] lockCounter
);

    logic                                     halfSymStrobe;
    logic                                     useSummer;
    logic                                     railMode;
    logic signed [sampleWidth-1:0]            mfI;
    logic signed [sampleWidth-1:0]            mfQ;
    logic signed [bitSyncPkg::errorWidth-1:0] timingError;
    logic                                     errorValid;
    logic                                     transition;
    logic [bitSyncPkg::errorWidth-1:0]        absError;
    logic [bitSyncPkg::errorWidth-1:0]        absSlipError;
    logic [bitSyncPkg::lockCountWidth-1:0]    lockReload;

    sampleSummer #(
        .sampleWidth(sampleWidth)
    ) summer (
        .sampleClk(sampleClk),
        .reset(reset),
        .strobe(halfSymStrobe),
        .useSummer(useSummer),
        .i(i),
        .q(q),
        .mfI(mfI),
        .mfQ(mfQ)
    );

    timingErrorDetector #(
        .sampleWidth(sampleWidth)
    ) detector (
        .sampleClk(sampleClk),
        .reset(reset),
        .strobe(halfSymStrobe),
        .railMode(railMode),
        .mfI(mfI),
        .mfQ(mfQ),
        .symValid(symValid),
        .symDataI(symDataI),
        .symDataQ(symDataQ),
        .bitDataI(bitDataI),
        .bitDataQ(bitDataQ),
        .timingError(timingError),
        .errorValid(errorValid),
        .transition(transition),
        .absError(absError),
        .absSlipError(absSlipError),
        .offsetError(offsetError),
        .offsetErrorValid(offsetErrorValid)
    );

    loopFilter filter (
        .sampleClk(sampleClk),
        .reset(reset),
        .sampleValid(sampleValid),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWriteData(regWriteData),
        .timingError(timingError),
        .errorValid(errorValid),
        .regReadData(regReadData),
        .halfSymStrobe(halfSymStrobe),
        .sampleFreq(sampleFreq),
        .useSummer(useSummer),
        .railMode(railMode),
        .lockReload(lockReload)
    );

    lockDetector lock (
        .sampleClk(sampleClk),
        .reset(reset),
        .errorValid(errorValid),
        .transition(transition),
        .absError(absError),
        .absSlipError(absSlipError),
        .lockReload(lockReload),
        .bitSyncLock(bitSyncLock),
        .lockCounter(lockCounter)
    );

endmodule

// ==== bench/bitSync_asserts.sv ====
`timescale 1ns/1ns

module bitSyncAsserts (
    input logic sampleClk,
    input logic reset,
    input logic sampleValid,
    input logic halfSymStrobe,
    input logic symValid,
    input logic offsetErrorValid,
    input logic bitSyncLock
);

    int failCount = 0;

    // NCO only carries on a valid sample
    strobeAfterValid: assert property (@(posedge sampleClk) disable iff (reset)
        halfSymStrobe |-> $past(sampleValid))
        else begin
            failCount++;
            $error("halfSymStrobe high without a valid sample in the cycle before");
        end

    symValidPulse: assert property (@(posedge sampleClk) disable iff (reset)
        symValid |=> !symValid)
        else begin
            failCount++;
            $error("symValid held high for more than one cycle");
        end

    offsetValidPulse: assert property (@(posedge sampleClk) disable iff (reset)
        offsetErrorValid |=> !offsetErrorValid)
        else begin
            failCount++;
            $error("offsetErrorValid held high for more than one cycle");
        end

    // Synchronous reset clears lock on the next edge
    lockLowInReset: assert property (@(posedge sampleClk)
        reset |=> !bitSyncLock)
        else begin
            failCount++;
            $error("bitSyncLock high while reset is applied");
        end

endmodule

bind bitSyncTop bitSyncAsserts bindChecks (
    .sampleClk(sampleClk),
    .reset(reset),
    .sampleValid(sampleValid),
    .halfSymStrobe(halfSymStrobe),
    .symValid(symValid),
    .offsetErrorValid(offsetErrorValid),
    .bitSyncLock(bitSyncLock)
);

// ==== bench/bitSyncTb.sv ====
`timescale 1ns/1ns

module bitSyncTb;

    localparam int sw = bitSyncPkg::sampleWidthDefault;
    localparam int aw = bitSyncPkg::regAddrWidth;
    localparam int halfScale = 1 << (sw - 2);
    localparam int maxSymbols = 1024;
    localparam int lockTimeout = 60000;

    logic                   sampleClk = 1'b0;
    logic                   reset = 1'b1;
    logic signed [sw-1:0]   i = '0;
    logic signed [sw-1:0]   q = '0;
    logic                   sampleValid = 1'b0;
    logic                   regWrite = 1'b0;
    logic [aw-1:0]          regAddr = '0;
    logic [31:0]            regWriteData = '0;
    logic [31:0]            regReadData;
    logic                   symValid;
    logic signed [sw-1:0]   symDataI;
    logic signed [sw-1:0]   symDataQ;
    logic                   bitDataI;
    logic                   bitDataQ;
    logic signed [sw-1:0]   offsetError;
    logic                   offsetErrorValid;
    logic [31:0]            sampleFreq;
    logic                   bitSyncLock;
    logic [15:0]            lockCounter;

    // Symbol generator state
    logic [31:0] rngState = 32'd73;
    int          symPhase = 0;
    int          sps10 = 80;
    int          dcOffset = 0;
    bit          randomSigns = 1'b0;
    bit          symBitI = 1'b0;
    bit          symBitQ = 1'b0;
    bit          sentI [maxSymbols];
    bit          sentQ [maxSymbols];
    bit          gotI [maxSymbols];
    bit          gotQ [maxSymbols];
    int          nSent = 0;
    int          nGot = 0;
    int          errorCount = 0;
    int          checkCount = 0;

    always #20 sampleClk = !sampleClk;

    bitSyncTop #(
        .sampleWidth(sw)
    ) UUT (
        .sampleClk(sampleClk),
        .reset(reset),
        .i(i),
        .q(q),
        .sampleValid(sampleValid),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWriteData(regWriteData),
        .regReadData(regReadData),
        .symValid(symValid),
        .symDataI(symDataI),
        .symDataQ(symDataQ),
        .bitDataI(bitDataI),
        .bitDataQ(bitDataQ),
        .offsetError(offsetError),
        .offsetErrorValid(offsetErrorValid),
        .sampleFreq(sampleFreq),
        .bitSyncLock(bitSyncLock),
        .lockCounter(lockCounter)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic signed [sw-1:0] levelFor(input bit b);
        int lvl;
        lvl = (b ? halfScale : -halfScale) + dcOffset;
        return sw'(lvl);
    endfunction

    task automatic checkValue(input string name, input longint expected, input longint actual,
                              input longint tol);
        checkCount++;
        assert (actual >= expected - tol && actual <= expected + tol) else begin
            errorCount++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("Error: %s", what);
    endtask

    task automatic applyReset();
        @(negedge sampleClk);
        reset = 1'b1;
        sampleValid = 1'b0;
        regWrite = 1'b0;
        repeat (16) @(negedge sampleClk);
        reset = 1'b0;
        symPhase = 0;
        nSent = 0;
        nGot = 0;
        dcOffset = 0;
        randomSigns = 1'b0;
        sps10 = 80;
    endtask

    task automatic writeReg(input logic [aw-1:0] addr, input logic [31:0] data);
        @(negedge sampleClk);
        regWrite = 1'b1;
        regAddr = addr;
        regWriteData = data;
        @(negedge sampleClk);
        regWrite = 1'b0;
    endtask

    task automatic readReg(input logic [aw-1:0] addr, output logic [31:0] data);
        @(negedge sampleClk);
        regAddr = addr;
        #1;
        data = regReadData;
    endtask

    // One sample per call with the symbol length in tenths of a sample
    task automatic stepSample();
        @(negedge sampleClk);
        if (randomSigns) begin
            rngState = xorshift(rngState);
            i = levelFor(rngState[31]);
            q = levelFor(rngState[30]);
        end else begin
            if (symPhase <= 0) begin
                symPhase += sps10;
                rngState = xorshift(rngState);
                symBitI = rngState[31];
                rngState = xorshift(rngState);
                symBitQ = rngState[31];
                if (nSent < maxSymbols) begin
                    sentI[nSent] = symBitI;
                    sentQ[nSent] = symBitQ;
                    nSent++;
                end
            end
            symPhase -= 10;
            i = levelFor(symBitI);
            q = levelFor(symBitQ);
        end
        sampleValid = 1'b1;
    endtask

    task automatic collectSymbol();
        if (nGot < maxSymbols) begin
            gotI[nGot] = bitDataI;
            gotQ[nGot] = bitDataQ;
            nGot++;
        end
    endtask

    function automatic int countMismatches(input bit railQ, input int offset);
        int bad;
        bad = 0;
        // First symbols still carry pipeline fill
        for (int j = 4; j < nGot - 4; j++) begin
            if (j + offset >= 0 && j + offset < nSent) begin
                if (railQ && gotQ[j] != sentQ[j + offset]) begin
                    bad++;
                end
                if (!railQ && gotI[j] != sentI[j + offset]) begin
                    bad++;
                end
            end
        end
        return bad;
    endfunction

    task automatic checkBits(input string name, input bit railQ);
        int best;
        int bad;
        best = nGot;
        for (int k = -3; k <= 3; k++) begin
            bad = countMismatches(railQ, k);
            if (bad < best) begin
                best = bad;
            end
        end
        checkValue(name, 0, best, 0);
    endtask

    task automatic testResetAndRegisters();
        logic [31:0] value;
        logic [31:0] resetValues [5];
        logic [31:0] newValues [4];
        resetValues = '{32'h4000_0000, 32'h0000_1F1F, 32'h1, 32'h4, 32'h4000_0000};
        newValues = '{32'h1234_5678, 32'h0000_0A04, 32'h3, 32'h9};
        applyReset();
        checkValue("reset symValid", 0, longint'(symValid), 0);
        checkValue("reset offsetErrorValid", 0, longint'(offsetErrorValid), 0);
        checkValue("reset bitSyncLock", 0, longint'(bitSyncLock), 0);
        checkValue("reset lockCounter", 0, longint'(lockCounter), 0);
        for (int k = 0; k < 5; k++) begin
            readReg(aw'(k), value);
            checkValue($sformatf("register %0d reset", k), longint'(resetValues[k]),
                       longint'(value), 0);
        end
        for (int k = 0; k < 4; k++) begin
            writeReg(aw'(k), newValues[k]);
        end
        for (int k = 0; k < 4; k++) begin
            readReg(aw'(k), value);
            checkValue($sformatf("register %0d readback", k), longint'(newValues[k]),
                       longint'(value), 0);
        end
        readReg(bitSyncPkg::regSampleFreq, value);
        checkValue("sampleFreq readback", longint'(newValues[0]), longint'(value), 0);
    endtask

    task automatic testOpenLoopRate();
        logic [31:0] freq;
        int pulses;
        freq = 32'h3000_0000;
        pulses = 0;
        applyReset();
        writeReg(bitSyncPkg::regNomFreq, freq);
        writeReg(bitSyncPkg::regGains, 32'h0000_1F1F);
        repeat (4096) begin
            stepSample();
            if (symValid) begin
                pulses++;
            end
        end
        checkValue("open loop symbol count", (longint'(freq) * 4096) >> 33, pulses, 1);
        checkValue("open loop sampleFreq", longint'(freq), longint'(sampleFreq), 0);
    endtask

    task automatic testSingleRail();
        applyReset();
        // Summer bypassed so every strobe sees a clean level
        writeReg(bitSyncPkg::regControl, 32'h0);
        repeat (1600) begin
            stepSample();
            if (symValid) begin
                checkValue("single rail bitDataQ", longint'(bitDataI), longint'(bitDataQ), 0);
                if (nGot >= 4) begin
                    checkValue("single rail symDataI", longint'(levelFor(bitDataI)),
                               longint'(symDataI), 0);
                end
                collectSymbol();
            end
        end
        checkValue("single rail symbol count", 200, nGot, 2);
        checkBits("single rail I bit errors", 1'b0);
    endtask

    task automatic testDualRailOffset();
        int edges;
        edges = 0;
        applyReset();
        writeReg(bitSyncPkg::regControl, 32'h2);
        dcOffset = -1500;
        repeat (1600) begin
            stepSample();
            if (symValid) begin
                checkValue("dual rail offsetErrorValid", 1, longint'(offsetErrorValid), 0);
                if (nGot >= 4) begin
                    checkValue("dual rail symDataQ", longint'(levelFor(bitDataQ)),
                               longint'(symDataQ), 0);
                end
                if (nGot >= 4 && bitDataI != gotI[nGot-1]) begin
                    checkValue("dual rail offsetError", dcOffset, longint'(offsetError), 1);
                    edges++;
                end
                collectSymbol();
            end
        end
        if (edges < 50) begin
            reportProblem("too few transitions seen to check the offset error");
        end
        checkBits("dual rail I bit errors", 1'b0);
        checkBits("dual rail Q bit errors", 1'b1);
    endtask

    task automatic testTrackingLock();
        longint target;
        longint freqSum;
        int waited;
        target = (longint'(1) << 33) * 10 / 82;
        freqSum = 0;
        waited = 0;
        applyReset();
        writeReg(bitSyncPkg::regGains, 32'h0000_0A04);
        sps10 = 82;
        while (!bitSyncLock && waited < lockTimeout) begin
            stepSample();
            waited++;
        end
        if (!bitSyncLock) begin
            reportProblem("bitSyncLock did not rise at 8.2 samples per symbol");
        end
        repeat (2048) begin
            stepSample();
            freqSum += longint'(sampleFreq);
        end
        checkValue("tracked sampleFreq", target, freqSum / 2048, target * 3 / 100);
        randomSigns = 1'b1;
        waited = 0;
        while (bitSyncLock && waited < lockTimeout) begin
            stepSample();
            waited++;
        end
        if (bitSyncLock) begin
            reportProblem("bitSyncLock did not fall on random input");
        end
        randomSigns = 1'b0;
    endtask

    initial begin
        testResetAndRegisters();
        testOpenLoopRate();
        testSingleRail();
        testDualRailOffset();
        testTrackingLock();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, UUT.bindChecks.failCount);
        if (errorCount == 0 && UUT.bindChecks.failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/bitSyncPkg.sv
source/sampleSummer.sv
source/timingErrorDetector.sv
source/loopFilter.sv
source/lockDetector.sv
source/bitSyncTop.sv
bench/bitSync_asserts.sv
bench/bitSyncTb.sv

// ==== Bender.yml ====
package:
  name: bit_sync

sources:
  - source/bitSyncPkg.sv
  - source/sampleSummer.sv
  - source/timingErrorDetector.sv
  - source/loopFilter.sv
  - source/lockDetector.sv
  - source/bitSyncTop.sv
  - target: simulation
    files:
      - bench/bitSync_asserts.sv
      - bench/bitSyncTb.sv
